/* all.f */
+incdir+src
src/db_bus_pkg.sv
src/db_io_pkg.sv
src/timed_cmd_queue.sv
src/setting_reg.sv
src/gpio_atr.sv
src/spi_master.sv
src/db_control.sv
verification/db_control_checker.sv
verification/db_control_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the db_control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module db_control_tb -f all.f

# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/Vdb_control_tb +verilator+error+limit+1000 || true)
echo "$out"

echo "$out" | grep -qx "sim passed"

/* verification/db_control_tb.sv */
//******************************
// daughterboard control testbench,
// timed writes, credits, GPIO and SPI
//******************************
`timescale 1ns/1ns
`include "db_ctrl_cfg.svh"

module db_control_tb;

  localparam int max_cycles = 20000;   // far above the length of all tests together

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic set_stb = 1'b0, run_rx = 1'b0, run_tx = 1'b0;
  logic miso, cmd_credit, sync, sclk, mosi, sclk_prev;
  db_bus_pkg::set_addr_t  set_addr = '0, rb_addr = '0;
  db_bus_pkg::set_data_t  set_data = '0;
  db_bus_pkg::vita_time_t set_time = '0, vita_time = '0, stamp;
  db_bus_pkg::rb_data_t   rb_data, rb_exp;
  db_io_pkg::gpio_word_t  misc_ins = '0, fp_gpio_in = '0, db_gpio_in = '0;
  db_io_pkg::gpio_word_t  misc_outs, leds, fp_gpio_out, fp_gpio_oe, db_gpio_out, db_gpio_oe;
  logic [7:0]  sen, mask, sen_exp, spi_rb_exp;
  logic [31:0] leds_exp, misc_exp;
  logic [31:0] atr_val [5];    // indexed by bank register offset
  logic [31:0] spi_data [2];
  int errors = 0, cycles = 0, sent = 0, returned = 0, hits, rises;
  int seed = 32'h9abf0120;

  db_control u_dut (.*);

  assign miso = mosi;   // spi loopback

  always #5 clk = ~clk;

  always @(posedge clk) begin
    vita_time <= rst ? 64'd0 : vita_time + 64'd1;
    cycles    <= cycles + 1;
    if (cmd_credit)
      returned <= returned + 1;
    if (cycles == max_cycles) begin
      $display("timeout after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // one settings write, held back while no credit is left
  task automatic send(input db_bus_pkg::set_addr_t a, input db_bus_pkg::set_data_t d,
                      input db_bus_pkg::vita_time_t t);
    @(posedge clk);
    while (sent - returned >= `DB_CMD_DEPTH)
      @(posedge clk);
    set_stb  <= 1'b1;
    set_addr <= a;
    set_data <= d;
    set_time <= t;
    sent++;
    @(posedge clk);
    set_stb <= 1'b0;
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
    else begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  initial begin
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // timed release, then a past stamp and a sync pulse
    stamp    = vita_time + 64'd40;
    leds_exp = $random(seed);
    send(8'(`DB_SR_LEDS), leds_exp, stamp);
    while (vita_time < stamp) begin
      @(negedge clk);
      check("leds held", 64'd0, 64'(leds));
    end
    repeat (3) @(negedge clk);
    check("leds at stamp", 64'(leds_exp), 64'(leds));
    leds_exp = $random(seed);
    send(8'(`DB_SR_LEDS), leds_exp, 64'd0);
    repeat (3) @(negedge clk);
    check("leds past stamp", 64'(leds_exp), 64'(leds));
    send(8'(`DB_SR_SYNC), 32'd1, 64'd0);
    hits = 0;
    repeat (4) begin
      @(negedge clk);
      if (sync)
        hits++;
    end
    check("sync pulse", 64'd1, 64'(hits));

    // burst beyond the queue depth stalls on credits
    stamp = vita_time + 64'd100;
    for (int i = 0; i < `DB_CMD_DEPTH + 4; i++) begin
      leds_exp = $random(seed);
      send(8'(`DB_SR_LEDS), leds_exp, stamp);
    end
    check("credit stall", 64'd1, 64'(vita_time >= stamp));
    repeat (30) @(negedge clk);
    check("burst credits", 64'd0, 64'(sent - returned));
    check("burst leds", 64'(leds_exp), 64'(leds));

    // clear drops everything still pending
    stamp = vita_time + 64'd200;
    for (int i = 0; i < 4; i++)
      send(8'(i[0] ? `DB_SR_MISC_OUTS : `DB_SR_LEDS), $random(seed), stamp);
    send(8'(`DB_SR_CLEAR), 32'd1, 64'd0);
    repeat (20) @(negedge clk);
    check("clear credits", 64'd0, 64'(sent - returned));
    while (vita_time <= stamp)
      @(negedge clk);
    repeat (3) @(negedge clk);
    check("clear leds", 64'(leds_exp), 64'(leds));
    check("clear misc_outs", 64'd0, 64'(misc_outs));

    // ATR banks, fp first then db
    for (int b = 0; b < 2; b++) begin
      for (int k = 0; k < 5; k++) begin
        atr_val[3'(k)] = $random(seed);
        send(8'((b == 0 ? `DB_SR_FP_GPIO : `DB_SR_DB_GPIO) + k), atr_val[3'(k)], 64'd0);
      end
      for (int s = 0; s < 4; s++) begin
        @(posedge clk);
        run_rx <= s[0];
        run_tx <= s[1];
        repeat (2) @(negedge clk);
        // idle, rx, tx and fdx sit at offsets 0 to 3 in state order
        check("atr out", 64'(atr_val[3'(s)]), 64'(b == 0 ? fp_gpio_out : db_gpio_out));
        check("atr oe", 64'(atr_val[3'(`DB_GPIO_OFS_DDR)]),
              64'(b == 0 ? fp_gpio_oe : db_gpio_oe));
      end
    end

    // spi loopback, 16 bits, divider 2, second write queued behind the first
    mask    = 8'($random(seed)) | 8'h01;
    sen_exp = ~mask;
    @(posedge clk);
    rb_addr <= 8'(`DB_RB_SPI);
    send(8'(`DB_SR_SPI), {10'd0, 6'd16, 8'd2, mask}, 64'd0);
    spi_data[0] = $random(seed);
    spi_data[1] = $random(seed);
    send(8'(`DB_SR_SPI + 1), spi_data[0], 64'd0);
    send(8'(`DB_SR_SPI + 1), spi_data[1], 64'd0);
    @(negedge clk);
    for (int i = 0; i < 2; i++) begin
      while (rb_data[32])
        @(negedge clk);
      rises     = 0;
      sclk_prev = 1'b0;
      while (!rb_data[32]) begin
        check("spi sen", 64'(sen_exp), 64'(sen));
        if (sclk && !sclk_prev)
          rises++;   // one rising sclk per bit
        sclk_prev = sclk;
        @(negedge clk);
      end
      check("spi sclk rises", 64'd16, 64'(rises));
      check("spi sclk idle", 64'd0, 64'(sclk));
      spi_rb_exp = 8'(spi_data[1'(i)] >> 16);   // bits 23:16 go out last
      check("spi readback", 64'(spi_rb_exp), 64'(rb_data[7:0]));
    end

    // readback map
    misc_exp = $random(seed);
    send(8'(`DB_SR_MISC_OUTS), misc_exp, 64'd0);
    @(posedge clk);
    misc_ins   <= $random(seed);
    fp_gpio_in <= $random(seed);
    db_gpio_in <= $random(seed);
    repeat (4) @(negedge clk);
    for (int a = 0; a < 7; a++) begin
      @(posedge clk);
      rb_addr <= 8'(a);
      @(negedge clk);
      case (a)
        `DB_RB_MISC_IO: rb_exp = {misc_ins, misc_exp};
        `DB_RB_SPI:     rb_exp = {31'd0, 1'b1, 24'd0, spi_rb_exp};
        `DB_RB_LEDS:    rb_exp = {32'd0, leds_exp};
        `DB_RB_DB_GPIO: rb_exp = {32'd0, db_gpio_in};
        `DB_RB_FP_GPIO: rb_exp = {32'd0, fp_gpio_in};
        default:        rb_exp = `DB_BAD_READ;
      endcase
      check("readback map", rb_exp, rb_data);
    end

    repeat (5) @(negedge clk);
    $display("value errors %0d, assertion failures %0d, writes %0d, credits %0d",
             errors, u_dut.u_checker.fail_count, sent, returned);
    if (errors == 0 && u_dut.u_checker.fail_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

/* verification/db_control_checker.sv */
//******************************
// bound assertions on queue credits,
// SPI enables and ATR directions
//******************************
`timescale 1ns/1ns
`include "db_ctrl_cfg.svh"

module db_control_checker (
  input logic                  clk,
  input logic                  rst,
  input logic                  set_stb,
  input logic                  cmd_credit,
  input logic                  spi_ready,
  input logic [7:0]            sen,
  input logic                  set_stb_timed,
  input db_bus_pkg::set_addr_t set_addr_timed,
  input db_io_pkg::gpio_word_t fp_gpio_oe,
  input db_io_pkg::gpio_word_t db_gpio_oe
);

  int          outstanding;      // accepted writes minus credit pulses
  int unsigned fail_count = 0;
  logic        fp_ddr_wr, db_ddr_wr;

  assign fp_ddr_wr = set_stb_timed &&
                     (set_addr_timed == 8'(`DB_SR_FP_GPIO + `DB_GPIO_OFS_DDR));
  assign db_ddr_wr = set_stb_timed &&
                     (set_addr_timed == 8'(`DB_SR_DB_GPIO + `DB_GPIO_OFS_DDR));

  always_ff @(posedge clk) begin
    if (rst)
      outstanding <= 0;
    else
      outstanding <= outstanding + int'(set_stb) - int'(cmd_credit);
  end

  // credits return only for accepted writes and never exceed the queue
  credit_bound: assert property (@(posedge clk) disable iff (rst)
    (outstanding >= 0) && (outstanding <= `DB_CMD_DEPTH))
    else begin
      fail_count++;
      $error("outstanding credit count outside zero to queue depth");
    end

  // chip selects released whenever the master is idle
  sen_idle: assert property (@(posedge clk) disable iff (rst)
    spi_ready |-> (sen == 8'hff))
    else begin
      fail_count++;
      $error("chip select active while spi idle");
    end

  fp_oe_write: assert property (@(posedge clk) disable iff (rst)
    !$stable(fp_gpio_oe) |-> $past(fp_ddr_wr))
    else begin
      fail_count++;
      $error("fp gpio direction moved without a direction write");
    end

  db_oe_write: assert property (@(posedge clk) disable iff (rst)
    !$stable(db_gpio_oe) |-> $past(db_ddr_wr))
    else begin
      fail_count++;
      $error("db gpio direction moved without a direction write");
    end

endmodule

bind db_control db_control_checker u_checker (
  .clk(clk), .rst(rst), .set_stb(set_stb), .cmd_credit(cmd_credit),
  .spi_ready(spi_ready), .sen(sen),
  .set_stb_timed(set_stb_timed), .set_addr_timed(set_addr_timed),
  .fp_gpio_oe(fp_gpio_oe), .db_gpio_oe(db_gpio_oe));

/* src/db_control.sv */
//*****************************
// daughterboard control top, timed
// settings, GPIO, SPI and readback
//*****************************
`timescale 1ns/1ns
`include "db_ctrl_cfg.svh"

module db_control (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   set_stb,
  input  db_bus_pkg::set_addr_t  set_addr,
  input  db_bus_pkg::set_data_t  set_data,
  input  db_bus_pkg::vita_time_t set_time,
  input  db_bus_pkg::set_addr_t  rb_addr,
  input  db_bus_pkg::vita_time_t vita_time,
  input  logic                   run_rx,
  input  logic                   run_tx,
  input  db_io_pkg::gpio_word_t  misc_ins,
  input  db_io_pkg::gpio_word_t  fp_gpio_in,
  input  db_io_pkg::gpio_word_t  db_gpio_in,
  input  logic                   miso,
  output logic                   cmd_credit,
  output db_bus_pkg::rb_data_t   rb_data,
  output db_io_pkg::gpio_word_t  misc_outs,
  output logic                   sync,
  output db_io_pkg::gpio_word_t  fp_gpio_out,
  output db_io_pkg::gpio_word_t  fp_gpio_oe,
  output db_io_pkg::gpio_word_t  db_gpio_out,
  output db_io_pkg::gpio_word_t  db_gpio_oe,
  output db_io_pkg::gpio_word_t  leds,
  output logic [7:0]             sen,
  output logic                   sclk,
  output logic                   mosi
);

  // released settings bus
  logic                  set_stb_timed;
  db_bus_pkg::set_addr_t set_addr_timed;
  db_bus_pkg::set_data_t set_data_timed;

  logic                  spi_ready, clear_cmd;
  logic [7:0]            spi_readback;
  db_io_pkg::gpio_word_t fp_gpio_readback, db_gpio_readback;

  timed_cmd_queue u_queue (
    .clk(clk), .rst(rst),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data), .set_time(set_time),
    .vita_time(vita_time), .spi_ready(spi_ready), .clear_cmd(clear_cmd),
    .cmd_credit(cmd_credit),
    .set_stb_timed(set_stb_timed), .set_addr_timed(set_addr_timed),
    .set_data_timed(set_data_timed));

  setting_reg #(.reg_addr(`DB_SR_MISC_OUTS), .payload_t(db_io_pkg::gpio_word_t))
  u_sr_misc_outs (
    .clk(clk), .rst(rst),
    .strobe(set_stb_timed), .addr(set_addr_timed), .data(set_data_timed),
    .out(misc_outs), .changed());

  setting_reg #(.reg_addr(`DB_SR_SYNC), .payload_t(logic)) u_sr_sync (
    .clk(clk), .rst(rst),
    .strobe(set_stb_timed), .addr(set_addr_timed), .data(set_data_timed),
    .out(), .changed(sync));   // only the pulse matters

  setting_reg #(.reg_addr(`DB_SR_LEDS), .payload_t(db_io_pkg::gpio_word_t)) u_sr_leds (
    .clk(clk), .rst(rst),
    .strobe(set_stb_timed), .addr(set_addr_timed), .data(set_data_timed),
    .out(leds), .changed());

  setting_reg #(.reg_addr(`DB_SR_CLEAR), .payload_t(logic)) u_sr_clear (
    .clk(clk), .rst(rst),
    .strobe(set_stb_timed), .addr(set_addr_timed), .data(set_data_timed),
    .out(), .changed(clear_cmd));

  gpio_atr #(.bank_base(`DB_SR_FP_GPIO)) u_fp_gpio (
    .clk(clk), .rst(rst),
    .set_stb(set_stb_timed), .set_addr(set_addr_timed), .set_data(set_data_timed),
    .run_rx(run_rx), .run_tx(run_tx), .gpio_in(fp_gpio_in),
    .gpio_out(fp_gpio_out), .gpio_oe(fp_gpio_oe), .gpio_readback(fp_gpio_readback));

  gpio_atr #(.bank_base(`DB_SR_DB_GPIO)) u_db_gpio (
    .clk(clk), .rst(rst),
    .set_stb(set_stb_timed), .set_addr(set_addr_timed), .set_data(set_data_timed),
    .run_rx(run_rx), .run_tx(run_tx), .gpio_in(db_gpio_in),
    .gpio_out(db_gpio_out), .gpio_oe(db_gpio_oe), .gpio_readback(db_gpio_readback));

  spi_master u_spi (
    .clk(clk), .rst(rst),
    .set_stb(set_stb_timed), .set_addr(set_addr_timed), .set_data(set_data_timed),
    .miso(miso), .sen(sen), .sclk(sclk), .mosi(mosi),
    .spi_ready(spi_ready), .spi_readback(spi_readback));

  // readback mux, purely combinational
  always_comb begin
    case (rb_addr)
      8'(`DB_RB_MISC_IO): rb_data = {misc_ins, misc_outs};
      8'(`DB_RB_SPI):     rb_data = {31'd0, spi_ready, 24'd0, spi_readback};
      8'(`DB_RB_LEDS):    rb_data = {32'd0, leds};
      8'(`DB_RB_DB_GPIO): rb_data = {32'd0, db_gpio_readback};
      8'(`DB_RB_FP_GPIO): rb_data = {32'd0, fp_gpio_readback};
      default:            rb_data = `DB_BAD_READ;
    endcase
  end

endmodule

/* src/spi_master.sv */
//*****************************
// SPI master, MSB first, up to 32 bits
// per transfer on eight chip selects
//*****************************
`timescale 1ns/1ns
`include "db_ctrl_cfg.svh"

module spi_master (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  set_stb,
  input  db_bus_pkg::set_addr_t set_addr,
  input  db_bus_pkg::set_data_t set_data,
  input  logic                  miso,
  output logic [7:0]            sen,
  output logic                  sclk,
  output logic                  mosi,
  output logic                  spi_ready,
  output logic [7:0]            spi_readback
);

  db_io_pkg::spi_cfg_t cfg;

  logic        wr_cfg, wr_data, start, tick;
  logic [7:0]  div_cnt;
  logic [5:0]  bit_cnt;      // bits sampled so far
  logic [31:0] shift_out;
  logic [7:0]  shift_in;     // last eight bits received

  assign wr_cfg  = set_stb && (set_addr == 8'(`DB_SR_SPI));
  assign wr_data = set_stb && (set_addr == 8'(`DB_SR_SPI + 1));
  assign start   = wr_data && spi_ready;

  // half period elapsed
  assign tick = !spi_ready && (div_cnt == cfg.divider);

  assign mosi = shift_out[31];

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg          <= '0;
      sen          <= '1;
      sclk         <= 1'b0;
      spi_ready    <= 1'b1;
      div_cnt      <= '0;
      bit_cnt      <= '0;
      spi_readback <= '0;
    end else begin
      if (wr_cfg)
        cfg <= db_io_pkg::spi_cfg_t'(set_data[21:0]);

      if (start) begin
        spi_ready <= 1'b0;
        sen       <= ~cfg.cs_mask;
        sclk      <= 1'b0;
        div_cnt   <= '0;
        bit_cnt   <= '0;
      end else if (tick) begin
        div_cnt <= '0;
        if (!sclk) begin
          sclk    <= 1'b1;               // rising edge, miso sampled below
          bit_cnt <= bit_cnt + 1'b1;
        end else begin
          sclk <= 1'b0;
          if (bit_cnt == cfg.num_bits) begin
            spi_ready    <= 1'b1;
            sen          <= '1;
            spi_readback <= shift_in;
          end
        end
      end else if (!spi_ready) begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // shift registers
  always_ff @(posedge clk) begin
    if (start)
      shift_out <= set_data;   // transfer starts at bit 31
    else if (tick && sclk)
      shift_out <= {shift_out[30:0], 1'b0};

    if (tick && !sclk)
      shift_in <= {shift_in[6:0], miso};
  end

endmodule

/* src/gpio_atr.sv */
//*****************************
// ATR GPIO bank, pin values follow
// the radio's rx/tx state
//*****************************
`timescale 1ns/1ns
`include "db_ctrl_cfg.svh"

module gpio_atr #(
  parameter int bank_base = 0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   set_stb,
  input  db_bus_pkg::set_addr_t  set_addr,
  input  db_bus_pkg::set_data_t  set_data,
  input  logic                   run_rx,
  input  logic                   run_tx,
  input  db_io_pkg::gpio_word_t  gpio_in,
  output db_io_pkg::gpio_word_t  gpio_out,
  output db_io_pkg::gpio_word_t  gpio_oe,
  output db_io_pkg::gpio_word_t  gpio_readback
);

  logic wr_idle, wr_rx, wr_tx, wr_fdx, wr_ddr;

  db_io_pkg::gpio_word_t idle_r, rx_r, tx_r, fdx_r;
  db_io_pkg::gpio_word_t idle_nx, rx_nx, tx_nx, fdx_nx, ddr_nx;
  db_io_pkg::gpio_word_t sel;
  db_io_pkg::atr_state_e state;

  function automatic logic bank_hit(input int ofs);
    return set_stb && (set_addr == 8'(bank_base + ofs));
  endfunction

  assign wr_idle = bank_hit(`DB_GPIO_OFS_IDLE);
  assign wr_rx   = bank_hit(`DB_GPIO_OFS_RX);
  assign wr_tx   = bank_hit(`DB_GPIO_OFS_TX);
  assign wr_fdx  = bank_hit(`DB_GPIO_OFS_FDX);
  assign wr_ddr  = bank_hit(`DB_GPIO_OFS_DDR);

  assign state = db_io_pkg::atr_state_e'({run_tx, run_rx});

  // forward the write so the pins move one cycle after it
  always_comb begin
    idle_nx = wr_idle ? set_data : idle_r;
    rx_nx   = wr_rx   ? set_data : rx_r;
    tx_nx   = wr_tx   ? set_data : tx_r;
    fdx_nx  = wr_fdx  ? set_data : fdx_r;
    ddr_nx  = wr_ddr  ? set_data : gpio_oe;
    case (state)
      db_io_pkg::rx:  sel = rx_nx;
      db_io_pkg::tx:  sel = tx_nx;
      db_io_pkg::fdx: sel = fdx_nx;
      default:        sel = idle_nx;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      idle_r   <= '0;
      rx_r     <= '0;
      tx_r     <= '0;
      fdx_r    <= '0;
      gpio_oe  <= '0;   // all pins inputs
      gpio_out <= '0;
    end else begin
      idle_r   <= idle_nx;
      rx_r     <= rx_nx;
      tx_r     <= tx_nx;
      fdx_r    <= fdx_nx;
      gpio_oe  <= ddr_nx;
      gpio_out <= sel;
    end
  end

  always_ff @(posedge clk) begin
    gpio_readback <= gpio_in;   // pin sample
  end

endmodule

/* src/setting_reg.sv */
//*****************************
// single addressed setting register
//*****************************
`timescale 1ns/1ns

module setting_reg #(
  parameter int       reg_addr  = 0,
  parameter type      payload_t = logic,
  parameter payload_t reset_val = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  strobe,
  input  db_bus_pkg::set_addr_t addr,
  input  db_bus_pkg::set_data_t data,
  output payload_t              out,
  output logic                  changed
);

  localparam int pw = $bits(payload_t);

  logic hit;

  assign hit = strobe && (addr == 8'(reg_addr));

  always_ff @(posedge clk) begin
    if (rst) begin
      out     <= reset_val;
      changed <= 1'b0;
    end else begin
      changed <= hit;   // one cycle pulse per write
      if (hit)
        out <= payload_t'(data[pw-1:0]);
    end
  end

endmodule

/* src/timed_cmd_queue.sv */
//*****************************
// timed command queue, holds settings
// writes until their stamp comes due
//*****************************
`timescale 1ns/1ns
`include "db_ctrl_cfg.svh"

module timed_cmd_queue (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   set_stb,
  input  db_bus_pkg::set_addr_t  set_addr,
  input  db_bus_pkg::set_data_t  set_data,
  input  db_bus_pkg::vita_time_t set_time,
  input  db_bus_pkg::vita_time_t vita_time,
  input  logic                   spi_ready,
  input  logic                   clear_cmd,
  output logic                   cmd_credit,
  output logic                   set_stb_timed,
  output db_bus_pkg::set_addr_t  set_addr_timed,
  output db_bus_pkg::set_data_t  set_data_timed
);

  localparam int depth = `DB_CMD_DEPTH;  // power of two, pointers wrap on their own
  localparam int ptr_w = $clog2(depth);

  db_bus_pkg::set_addr_t  addr_mem [depth];
  db_bus_pkg::set_data_t  data_mem [depth];
  db_bus_pkg::vita_time_t time_mem [depth];

  logic [ptr_w-1:0] head, tail;
  logic [ptr_w:0]   count;
  logic             flush_mode;
  logic             empty, full, push, pop, bypass, flushing;
  logic             head_due, head_in_range, spi_ok, release_now, drop_now;

  function automatic logic is_spi_addr(input db_bus_pkg::set_addr_t a);
    return (a == 8'(`DB_SR_SPI)) || (a == 8'(`DB_SR_SPI + 1));
  endfunction

  assign empty = (count == '0);
  assign full  = (count == (ptr_w+1)'(depth));

  // a clear that is already due overtakes queued entries
  assign bypass = set_stb && (set_addr == 8'(`DB_SR_CLEAR)) && (set_time <= vita_time);
  assign push   = set_stb && !bypass && !full;

  assign flushing      = flush_mode | clear_cmd;
  assign head_due      = (time_mem[head] <= vita_time);
  assign head_in_range = (addr_mem[head] < 8'(`DB_SR_RANGE));

  // spi_ready drops two cycles after a spi release, so block the gap cycle too
  assign spi_ok = spi_ready && !(set_stb_timed && is_spi_addr(set_addr_timed));

  assign drop_now    = !empty && !bypass && (flushing || !head_in_range);
  assign release_now = !empty && !bypass && !flushing && head_in_range && head_due &&
                       (spi_ok || !is_spi_addr(addr_mem[head]));
  assign pop         = drop_now | release_now;

  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[tail] <= set_addr;
      data_mem[tail] <= set_data;
      time_mem[tail] <= set_time;
    end
  end

  always_ff @(posedge clk) begin
    set_addr_timed <= bypass ? set_addr : addr_mem[head];
    set_data_timed <= bypass ? set_data : data_mem[head];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head          <= '0;
      tail          <= '0;
      count         <= '0;
      flush_mode    <= 1'b0;
      set_stb_timed <= 1'b0;
      cmd_credit    <= 1'b0;
    end else begin
      if (push) tail <= tail + 1'b1;
      if (pop)  head <= head + 1'b1;
      count <= count + (ptr_w+1)'(push) - (ptr_w+1)'(pop);

      if (clear_cmd)
        flush_mode <= 1'b1;
      else if (empty)
        flush_mode <= 1'b0;   // drained

      set_stb_timed <= release_now | bypass;
      cmd_credit    <= pop | bypass;   // one credit per entry that leaves
    end
  end

endmodule

/* src/db_io_pkg.sv */
//*****************************
// GPIO state and SPI config types
//*****************************
package db_io_pkg;

  typedef logic [31:0] gpio_word_t;

  // formed as {run_tx, run_rx}
  typedef enum logic [1:0] {
    idle = 2'd0,
    rx   = 2'd1,
    tx   = 2'd2,
    fdx  = 2'd3
  } atr_state_e;

  // spi config word, written at the spi config address
  typedef struct packed {
    logic [5:0] num_bits;   // 21:16, bits per transfer, 1 to 32
    logic [7:0] divider;    // 15:8, sclk half period minus one
    logic [7:0] cs_mask;    // 7:0, chip selects to assert
  } spi_cfg_t;

endpackage

/* src/db_bus_pkg.sv */
//*****************************
// settings and readback bus types
//*****************************
package db_bus_pkg;

  // settings bus
  typedef logic [7:0]  set_addr_t;
  typedef logic [31:0] set_data_t;

  typedef logic [63:0] vita_time_t;   // radio time counter and command stamps

  // readback word returned per rb_addr
  typedef logic [63:0] rb_data_t;

endpackage

/* src/db_ctrl_cfg.svh */
//*****************************
// daughterboard control address map,
// queue depth and readback default
//*****************************
`ifndef DB_CTRL_CFG_SVH
`define DB_CTRL_CFG_SVH

// settings addresses
`define DB_SR_MISC_OUTS 0
`define DB_SR_SYNC      1
`define DB_SR_CLEAR     2
`define DB_SR_SPI       16   // config at 16, data at 17
`define DB_SR_LEDS      24
`define DB_SR_FP_GPIO   32   // 32 to 37
`define DB_SR_DB_GPIO   48   // 48 to 53
`define DB_SR_RANGE     64   // queue only releases addresses below this

// readback addresses
`define DB_RB_MISC_IO   0
`define DB_RB_SPI       1
`define DB_RB_LEDS      2
`define DB_RB_DB_GPIO   3
`define DB_RB_FP_GPIO   4

`define DB_CMD_DEPTH    8    // also the producer's starting credit count
`define DB_BAD_READ     64'h0BAD_C0DE_0BAD_C0DE

// register offsets inside one GPIO bank, offset 5 is reserved
`define DB_GPIO_OFS_IDLE 0
`define DB_GPIO_OFS_RX   1
`define DB_GPIO_OFS_TX   2
`define DB_GPIO_OFS_FDX  3
`define DB_GPIO_OFS_DDR  4

`endif
